//--- hdl/addr_cmd_pad_out.sv
// address and command output registers
`timescale 1ns/1ps
`default_nettype none

module addr_cmd_pad_out (
    input  logic                                 pll_mem_clk,
    input  logic                                 rst_n,
    input  logic [addr_cmd_pkg::CMD_SLOT_W-1:0]  fr_slot,
    input  logic [addr_cmd_pkg::MEM_CK_W-1:0]    fr_ck_en,
    output logic [addr_cmd_pkg::MEM_ADDR_W-1:0]  mem_address,
    output logic [addr_cmd_pkg::MEM_BANK_W-1:0]  mem_bank,
    output logic [addr_cmd_pkg::MEM_CS_W-1:0]    mem_cs_n,
    output logic [addr_cmd_pkg::MEM_CKE_W-1:0]   mem_cke,
    output logic [addr_cmd_pkg::MEM_ODT_W-1:0]   mem_odt,
    output logic                                 mem_ras_n,
    output logic                                 mem_cas_n,
    output logic                                 mem_we_n,
    output logic                                 mem_reset_n,
    output logic                                 cmd_oe,
    output logic [addr_cmd_pkg::MEM_CK_W-1:0]    mem_ck_en
);

    // registered slot as seen on the pads
    logic [addr_cmd_pkg::CMD_SLOT_W-1:0] pad_slot;

    // ******************************************************************
    // output registers
    // ******************************************************************

    // the pads come out of reset as a deselected NOP with CKE low
    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pad_slot <= addr_cmd_pkg::IDLE_SLOT;
        end
        else
        begin
            pad_slot <= fr_slot;
        end
    end

    // command pins are driven while any memory clock is running
    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cmd_oe    <= 1'b0;
            mem_ck_en <= '0;
        end
        else
        begin
            cmd_oe    <= |fr_ck_en;
            mem_ck_en <= fr_ck_en;
        end
    end

    // ******************************************************************
    // field unpacking
    // ******************************************************************

    assign mem_address = pad_slot[addr_cmd_pkg::SLOT_ADDR_LSB +: addr_cmd_pkg::MEM_ADDR_W];
    assign mem_bank    = pad_slot[addr_cmd_pkg::SLOT_BANK_LSB +: addr_cmd_pkg::MEM_BANK_W];
    assign mem_cs_n    = pad_slot[addr_cmd_pkg::SLOT_CS_LSB +: addr_cmd_pkg::MEM_CS_W];
    assign mem_odt     = pad_slot[addr_cmd_pkg::SLOT_ODT_LSB +: addr_cmd_pkg::MEM_ODT_W];
    assign mem_ras_n   = pad_slot[addr_cmd_pkg::SLOT_RAS_BIT];
    assign mem_cas_n   = pad_slot[addr_cmd_pkg::SLOT_CAS_BIT];
    assign mem_we_n    = pad_slot[addr_cmd_pkg::SLOT_WE_BIT];

    // CKE and memory reset are driven whatever the clock gates say,
    // so the part can be held in reset or power-down with clocks off
    assign mem_cke     = pad_slot[addr_cmd_pkg::SLOT_CKE_LSB +: addr_cmd_pkg::MEM_CKE_W];
    assign mem_reset_n = pad_slot[addr_cmd_pkg::SLOT_RESET_BIT];

endmodule

`default_nettype wire

//--- hdl/addr_cmd_path.sv
// ddr3 address and command output path
`timescale 1ns/1ps
`default_nettype none

module addr_cmd_path (
    input  logic                                   pll_mem_clk,
    input  logic                                   rst_n,

    // half-rate command word from the controller
    input  logic [2*addr_cmd_pkg::MEM_ADDR_W-1:0]  afi_address,
    input  logic [2*addr_cmd_pkg::MEM_BANK_W-1:0]  afi_bank,
    input  logic [2*addr_cmd_pkg::MEM_CS_W-1:0]    afi_cs_n,
    input  logic [2*addr_cmd_pkg::MEM_CKE_W-1:0]   afi_cke,
    input  logic [2*addr_cmd_pkg::MEM_ODT_W-1:0]   afi_odt,
    input  logic [1:0]                             afi_ras_n,
    input  logic [1:0]                             afi_cas_n,
    input  logic [1:0]                             afi_we_n,
    input  logic [1:0]                             afi_reset_n,
    input  logic [addr_cmd_pkg::MEM_CK_W-1:0]      enable_mem_clk,

    // full-rate memory pins
    output logic [addr_cmd_pkg::MEM_ADDR_W-1:0]    mem_address,
    output logic [addr_cmd_pkg::MEM_BANK_W-1:0]    mem_bank,
    output logic [addr_cmd_pkg::MEM_CS_W-1:0]      mem_cs_n,
    output logic [addr_cmd_pkg::MEM_CKE_W-1:0]     mem_cke,
    output logic [addr_cmd_pkg::MEM_ODT_W-1:0]     mem_odt,
    output logic                                   mem_ras_n,
    output logic                                   mem_cas_n,
    output logic                                   mem_we_n,
    output logic                                   mem_reset_n,
    output logic                                   cmd_oe,
    output logic [addr_cmd_pkg::MEM_CK_W-1:0]      mem_ck_en,

    // tells the controller when a new word may be presented
    output addr_cmd_pkg::hr_phase_t                hr_phase
);

    // ******************************************************************
    // internal connections
    // ******************************************************************

    logic [addr_cmd_pkg::CMD_SLOT_W-1:0] captured_slot0;
    logic [addr_cmd_pkg::CMD_SLOT_W-1:0] captured_slot1;
    logic [addr_cmd_pkg::MEM_CK_W-1:0]   captured_ck_en;
    logic                                captured_strobe;
    logic [addr_cmd_pkg::CMD_SLOT_W-1:0] fr_slot;
    logic [addr_cmd_pkg::MEM_CK_W-1:0]   fr_ck_en;

    // ******************************************************************
    // capture, serialize, drive
    // ******************************************************************

    afi_cmd_capture u_capture (
        .pll_mem_clk     (pll_mem_clk),
        .rst_n           (rst_n),
        .afi_address     (afi_address),
        .afi_bank        (afi_bank),
        .afi_cs_n        (afi_cs_n),
        .afi_cke         (afi_cke),
        .afi_odt         (afi_odt),
        .afi_ras_n       (afi_ras_n),
        .afi_cas_n       (afi_cas_n),
        .afi_we_n        (afi_we_n),
        .afi_reset_n     (afi_reset_n),
        .enable_mem_clk  (enable_mem_clk),
        .captured_slot0  (captured_slot0),
        .captured_slot1  (captured_slot1),
        .captured_ck_en  (captured_ck_en),
        .captured_strobe (captured_strobe),
        .hr_phase        (hr_phase)
    );

    // slot 0 leaves two edges after sampling, slot 1 one edge later
    hr_to_fr_serializer u_serializer (
        .pll_mem_clk     (pll_mem_clk),
        .rst_n           (rst_n),
        .captured_slot0  (captured_slot0),
        .captured_slot1  (captured_slot1),
        .captured_ck_en  (captured_ck_en),
        .captured_strobe (captured_strobe),
        .fr_slot         (fr_slot),
        .fr_ck_en        (fr_ck_en)
    );

    addr_cmd_pad_out u_pad_out (
        .pll_mem_clk     (pll_mem_clk),
        .rst_n           (rst_n),
        .fr_slot         (fr_slot),
        .fr_ck_en        (fr_ck_en),
        .mem_address     (mem_address),
        .mem_bank        (mem_bank),
        .mem_cs_n        (mem_cs_n),
        .mem_cke         (mem_cke),
        .mem_odt         (mem_odt),
        .mem_ras_n       (mem_ras_n),
        .mem_cas_n       (mem_cas_n),
        .mem_we_n        (mem_we_n),
        .mem_reset_n     (mem_reset_n),
        .cmd_oe          (cmd_oe),
        .mem_ck_en       (mem_ck_en)
    );

endmodule

`default_nettype wire

//--- hdl/addr_cmd_pkg.sv
// ddr3 address and command path definitions
`default_nettype none

package addr_cmd_pkg;

    // ******************************************************************
    // memory pin field widths for one slot
    // ******************************************************************
    localparam int MEM_ADDR_W = 14;
    localparam int MEM_BANK_W = 3;
    localparam int MEM_CS_W   = 1;
    localparam int MEM_CKE_W  = 1;
    localparam int MEM_ODT_W  = 1;
    localparam int MEM_CK_W   = 1;

    // ******************************************************************
    // packed command slot layout
    // ******************************************************************
    localparam int CMD_SLOT_W = 24;

    // fields are stacked from bit 0 upward in pin order
    localparam int SLOT_ADDR_LSB  = 0;
    localparam int SLOT_BANK_LSB  = SLOT_ADDR_LSB + MEM_ADDR_W;
    localparam int SLOT_CS_LSB    = SLOT_BANK_LSB + MEM_BANK_W;
    localparam int SLOT_CKE_LSB   = SLOT_CS_LSB + MEM_CS_W;
    localparam int SLOT_ODT_LSB   = SLOT_CKE_LSB + MEM_CKE_W;
    localparam int SLOT_RAS_BIT   = SLOT_ODT_LSB + MEM_ODT_W;
    localparam int SLOT_CAS_BIT   = SLOT_RAS_BIT + 1;
    localparam int SLOT_WE_BIT    = SLOT_CAS_BIT + 1;
    localparam int SLOT_RESET_BIT = SLOT_WE_BIT + 1;

    // deselected NOP with CKE low and the memory held in reset
    // (all other fields stay zero)
    localparam logic [CMD_SLOT_W-1:0] IDLE_SLOT =
        (CMD_SLOT_W'((1 << MEM_CS_W) - 1) << SLOT_CS_LSB) |
        (CMD_SLOT_W'(1) << SLOT_RAS_BIT) |
        (CMD_SLOT_W'(1) << SLOT_CAS_BIT) |
        (CMD_SLOT_W'(1) << SLOT_WE_BIT);

    // ******************************************************************
    // half-rate phase tracking
    // ******************************************************************
    typedef enum logic {
        PHASE_SLOT0 = 1'b0,
        PHASE_SLOT1 = 1'b1
    } hr_phase_t;

    // edges spent detecting reset release before the phase starts
    localparam int PHASE_SYNC_STAGES = 2;

endpackage

`default_nettype wire

//--- hdl/afi_cmd_capture.sv
// half-rate command capture
`timescale 1ns/1ps
`default_nettype none

module afi_cmd_capture (
    input  logic                                   pll_mem_clk,
    input  logic                                   rst_n,
    input  logic [2*addr_cmd_pkg::MEM_ADDR_W-1:0]  afi_address,
    input  logic [2*addr_cmd_pkg::MEM_BANK_W-1:0]  afi_bank,
    input  logic [2*addr_cmd_pkg::MEM_CS_W-1:0]    afi_cs_n,
    input  logic [2*addr_cmd_pkg::MEM_CKE_W-1:0]   afi_cke,
    input  logic [2*addr_cmd_pkg::MEM_ODT_W-1:0]   afi_odt,
    input  logic [1:0]                             afi_ras_n,
    input  logic [1:0]                             afi_cas_n,
    input  logic [1:0]                             afi_we_n,
    input  logic [1:0]                             afi_reset_n,
    input  logic [addr_cmd_pkg::MEM_CK_W-1:0]      enable_mem_clk,
    output logic [addr_cmd_pkg::CMD_SLOT_W-1:0]    captured_slot0,
    output logic [addr_cmd_pkg::CMD_SLOT_W-1:0]    captured_slot1,
    output logic [addr_cmd_pkg::MEM_CK_W-1:0]      captured_ck_en,
    output logic                                   captured_strobe,
    output addr_cmd_pkg::hr_phase_t                hr_phase
);

    localparam int SYNC_MSB = addr_cmd_pkg::PHASE_SYNC_STAGES - 1;

    logic [SYNC_MSB:0] release_sync;

    // places one half of every field at its slot offset
    function automatic logic [addr_cmd_pkg::CMD_SLOT_W-1:0] pack_slot(
        input logic [addr_cmd_pkg::MEM_ADDR_W-1:0] addr,
        input logic [addr_cmd_pkg::MEM_BANK_W-1:0] bank,
        input logic [addr_cmd_pkg::MEM_CS_W-1:0]   cs_n,
        input logic [addr_cmd_pkg::MEM_CKE_W-1:0]  cke,
        input logic [addr_cmd_pkg::MEM_ODT_W-1:0]  odt,
        input logic                                ras_n,
        input logic                                cas_n,
        input logic                                we_n,
        input logic                                reset_n
    );
        logic [addr_cmd_pkg::CMD_SLOT_W-1:0] slot;
        slot = '0;
        slot[addr_cmd_pkg::SLOT_ADDR_LSB +: addr_cmd_pkg::MEM_ADDR_W] = addr;
        slot[addr_cmd_pkg::SLOT_BANK_LSB +: addr_cmd_pkg::MEM_BANK_W] = bank;
        slot[addr_cmd_pkg::SLOT_CS_LSB +: addr_cmd_pkg::MEM_CS_W]     = cs_n;
        slot[addr_cmd_pkg::SLOT_CKE_LSB +: addr_cmd_pkg::MEM_CKE_W]   = cke;
        slot[addr_cmd_pkg::SLOT_ODT_LSB +: addr_cmd_pkg::MEM_ODT_W]   = odt;
        slot[addr_cmd_pkg::SLOT_RAS_BIT]                              = ras_n;
        slot[addr_cmd_pkg::SLOT_CAS_BIT]                              = cas_n;
        slot[addr_cmd_pkg::SLOT_WE_BIT]                               = we_n;
        slot[addr_cmd_pkg::SLOT_RESET_BIT]                            = reset_n;
        return slot;
    endfunction

    // ******************************************************************
    // phase generator
    // ******************************************************************

    // a one walks up the chain after reset release and the phase stays
    // at slot 0 until it reaches the top
    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            release_sync <= '0;
            hr_phase     <= addr_cmd_pkg::PHASE_SLOT0;
        end
        else
        begin
            release_sync <= {release_sync[SYNC_MSB-1:0], 1'b1};
            if (!release_sync[SYNC_MSB])
                hr_phase <= addr_cmd_pkg::PHASE_SLOT0;
            else if (hr_phase == addr_cmd_pkg::PHASE_SLOT0)
                hr_phase <= addr_cmd_pkg::PHASE_SLOT1;
            else
                hr_phase <= addr_cmd_pkg::PHASE_SLOT0;
        end
    end

    // ******************************************************************
    // word capture
    // ******************************************************************

    // the strobe marks the cycle in which a fresh word is on the outputs
    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
            captured_strobe <= 1'b0;
        else
            captured_strobe <= (hr_phase == addr_cmd_pkg::PHASE_SLOT1);
    end

    // low halves go to slot 0 and high halves to slot 1
    always_ff @(posedge pll_mem_clk)
    begin
        if (hr_phase == addr_cmd_pkg::PHASE_SLOT1)
        begin
            captured_slot0 <= pack_slot(afi_address[addr_cmd_pkg::MEM_ADDR_W-1:0],
                                        afi_bank[addr_cmd_pkg::MEM_BANK_W-1:0],
                                        afi_cs_n[addr_cmd_pkg::MEM_CS_W-1:0],
                                        afi_cke[addr_cmd_pkg::MEM_CKE_W-1:0],
                                        afi_odt[addr_cmd_pkg::MEM_ODT_W-1:0],
                                        afi_ras_n[0], afi_cas_n[0],
                                        afi_we_n[0], afi_reset_n[0]);
            captured_slot1 <= pack_slot(afi_address[2*addr_cmd_pkg::MEM_ADDR_W-1 -: addr_cmd_pkg::MEM_ADDR_W],
                                        afi_bank[2*addr_cmd_pkg::MEM_BANK_W-1 -: addr_cmd_pkg::MEM_BANK_W],
                                        afi_cs_n[2*addr_cmd_pkg::MEM_CS_W-1 -: addr_cmd_pkg::MEM_CS_W],
                                        afi_cke[2*addr_cmd_pkg::MEM_CKE_W-1 -: addr_cmd_pkg::MEM_CKE_W],
                                        afi_odt[2*addr_cmd_pkg::MEM_ODT_W-1 -: addr_cmd_pkg::MEM_ODT_W],
                                        afi_ras_n[1], afi_cas_n[1],
                                        afi_we_n[1], afi_reset_n[1]);
            captured_ck_en <= enable_mem_clk;
        end
    end

endmodule

`default_nettype wire

//--- hdl/hr_to_fr_serializer.sv
// half-rate to full-rate slot serializer
`timescale 1ns/1ps
`default_nettype none

module hr_to_fr_serializer (
    input  logic                                 pll_mem_clk,
    input  logic                                 rst_n,
    input  logic [addr_cmd_pkg::CMD_SLOT_W-1:0]  captured_slot0,
    input  logic [addr_cmd_pkg::CMD_SLOT_W-1:0]  captured_slot1,
    input  logic [addr_cmd_pkg::MEM_CK_W-1:0]    captured_ck_en,
    input  logic                                 captured_strobe,
    output logic [addr_cmd_pkg::CMD_SLOT_W-1:0]  fr_slot,
    output logic [addr_cmd_pkg::MEM_CK_W-1:0]    fr_ck_en
);

    // slot 1 of the word currently being sent
    logic [addr_cmd_pkg::CMD_SLOT_W-1:0] pending_slot1;

    // which slot goes out at the next edge when no new word arrives
    addr_cmd_pkg::hr_phase_t next_slot;

    // ******************************************************************
    // slot selector
    // ******************************************************************

    // a strobe always wins, so back-to-back words leave no gap
    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            next_slot <= addr_cmd_pkg::PHASE_SLOT0;
        end
        else if (captured_strobe)
        begin
            next_slot <= addr_cmd_pkg::PHASE_SLOT1;
        end
        else if (next_slot == addr_cmd_pkg::PHASE_SLOT1)
        begin
            next_slot <= addr_cmd_pkg::PHASE_SLOT0;
        end
    end

    // ******************************************************************
    // full-rate output
    // ******************************************************************

    // slot 1 stays on the output until the following word is consumed
    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            fr_slot  <= addr_cmd_pkg::IDLE_SLOT;
            fr_ck_en <= '0;
        end
        else if (captured_strobe)
        begin
            fr_slot  <= captured_slot0;
            fr_ck_en <= captured_ck_en;
        end
        else if (next_slot == addr_cmd_pkg::PHASE_SLOT1)
        begin
            fr_slot <= pending_slot1;
        end
    end

    // the capture stage may reload before slot 1 is sent, so keep a copy
    always_ff @(posedge pll_mem_clk)
    begin
        if (captured_strobe)
            pending_slot1 <= captured_slot1;
    end

endmodule

`default_nettype wire

//--- list.f
hdl/addr_cmd_pkg.sv
hdl/afi_cmd_capture.sv
hdl/hr_to_fr_serializer.sv
hdl/addr_cmd_pad_out.sv
hdl/addr_cmd_path.sv
verification/addr_cmd_checker.sv
verification/addr_cmd_path_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the address and command path testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=addr_cmd_path_sim
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal \
    --top-module addr_cmd_path_tb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN" \
    -f list.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "run_sim: Verilator build failed with status $build_status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "run_sim: simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Simulation PASSED" "$LOG_FILE"; then
    exit 0
fi

echo "run_sim: pass message not found in $LOG_FILE"
exit 1

//--- verification/addr_cmd_checker.sv
// address and command pin checker
`timescale 1ns/1ps
`default_nettype none

module addr_cmd_checker (
    input  logic                                   pll_mem_clk,
    input  logic                                   rst_n,
    input  logic [2*addr_cmd_pkg::MEM_ADDR_W-1:0]  afi_address,
    input  logic [2*addr_cmd_pkg::MEM_BANK_W-1:0]  afi_bank,
    input  logic [2*addr_cmd_pkg::MEM_CS_W-1:0]    afi_cs_n,
    input  logic [2*addr_cmd_pkg::MEM_CKE_W-1:0]   afi_cke,
    input  logic [2*addr_cmd_pkg::MEM_ODT_W-1:0]   afi_odt,
    input  logic [1:0]                             afi_ras_n,
    input  logic [1:0]                             afi_cas_n,
    input  logic [1:0]                             afi_we_n,
    input  logic [1:0]                             afi_reset_n,
    input  logic [addr_cmd_pkg::MEM_CK_W-1:0]      enable_mem_clk,
    input  logic [addr_cmd_pkg::MEM_ADDR_W-1:0]    mem_address,
    input  logic [addr_cmd_pkg::MEM_BANK_W-1:0]    mem_bank,
    input  logic [addr_cmd_pkg::MEM_CS_W-1:0]      mem_cs_n,
    input  logic [addr_cmd_pkg::MEM_CKE_W-1:0]     mem_cke,
    input  logic [addr_cmd_pkg::MEM_ODT_W-1:0]     mem_odt,
    input  logic                                   mem_ras_n,
    input  logic                                   mem_cas_n,
    input  logic                                   mem_we_n,
    input  logic                                   mem_reset_n,
    input  logic                                   cmd_oe,
    input  logic [addr_cmd_pkg::MEM_CK_W-1:0]      mem_ck_en,
    input  addr_cmd_pkg::hr_phase_t                hr_phase,
    output int                                     error_count,
    output int                                     check_count,
    output int                                     words_sampled,
    output int                                     words_checked
);

    localparam int AW = addr_cmd_pkg::MEM_ADDR_W;
    localparam int BW = addr_cmd_pkg::MEM_BANK_W;
    localparam int SW = addr_cmd_pkg::MEM_CS_W;
    localparam int KW = addr_cmd_pkg::MEM_CKE_W;
    localparam int OW = addr_cmd_pkg::MEM_ODT_W;
    localparam int CW = addr_cmd_pkg::MEM_CK_W;

    // pins packed as address, bank, cs_n, cke, odt, ras_n, cas_n, we_n, reset_n, cmd_oe, ck_en
    localparam int PIN_W = AW + BW + SW + KW + OW + 5 + CW;

    // deselected NOP, CKE low, memory in reset, no clocks and no enable
    localparam logic [PIN_W-1:0] IDLE_PINS = {{AW{1'b0}}, {BW{1'b0}}, {SW{1'b1}},
        {KW{1'b0}}, {OW{1'b0}}, 3'b111, 1'b0, 1'b0, {CW{1'b0}}};

    int                      cycle;
    int                      slots_checked;
    int                      exp_due[$];
    logic [PIN_W-1:0]        exp_pins[$];
    int                      exp_word[$];
    int                      exp_slot[$];
    logic [PIN_W-1:0]        pins_now;
    addr_cmd_pkg::hr_phase_t exp_phase;

    // pins expected for slot s of the word now on the inputs
    function automatic logic [PIN_W-1:0] slot_pins(input int s);
        return {afi_address[s*AW +: AW], afi_bank[s*BW +: BW], afi_cs_n[s*SW +: SW],
                afi_cke[s*KW +: KW], afi_odt[s*OW +: OW], afi_ras_n[s], afi_cas_n[s],
                afi_we_n[s], afi_reset_n[s], |enable_mem_clk, enable_mem_clk};
    endfunction

    task automatic compare_pins(input logic [PIN_W-1:0] expected, input string what);
        check_count++;
        if (pins_now !== expected)
        begin
            error_count++;
            $display("ERROR %0t: %s, expected pins %h, got %h", $time, what, expected, pins_now);
        end
    endtask

    // ******************************************************************
    // edge by edge prediction and compare
    // ******************************************************************

    always @(posedge pll_mem_clk)
    begin
        pins_now = {mem_address, mem_bank, mem_cs_n, mem_cke, mem_odt,
                    mem_ras_n, mem_cas_n, mem_we_n, mem_reset_n, cmd_oe, mem_ck_en};
        if (!rst_n)
        begin
            cycle = 0;
            slots_checked = 0;
            exp_due.delete();
            exp_pins.delete();
            exp_word.delete();
            exp_slot.delete();
            compare_pins(IDLE_PINS, "pins under reset");
        end
        else
        begin
            cycle = cycle + 1;
            // the phase rests at slot 0 while the release detector fills
            if (cycle <= addr_cmd_pkg::PHASE_SYNC_STAGES + 1)
                exp_phase = addr_cmd_pkg::PHASE_SLOT0;
            else if ((cycle - addr_cmd_pkg::PHASE_SYNC_STAGES) % 2 == 0)
                exp_phase = addr_cmd_pkg::PHASE_SLOT1;
            else
                exp_phase = addr_cmd_pkg::PHASE_SLOT0;
            check_count++;
            if (hr_phase !== exp_phase)
            begin
                error_count++;
                $display("ERROR %0t: hr_phase is %0d at edge %0d after reset, expected %0d",
                         $time, hr_phase, cycle, exp_phase);
            end
            if (exp_due.size() > 0 && exp_due[0] == cycle)
            begin
                compare_pins(exp_pins[0],
                             $sformatf("slot %0d of word %0d", exp_slot[0], exp_word[0]));
                if (exp_slot[0] == 1)
                    words_checked = exp_word[0] + 1;
                slots_checked++;
                void'(exp_due.pop_front());
                void'(exp_pins.pop_front());
                void'(exp_word.pop_front());
                void'(exp_slot.pop_front());
            end
            else if (slots_checked == 0)
                compare_pins(IDLE_PINS, "pins before the first word");
            else
            begin
                error_count++;
                $display("ERROR %0t: no slot due at edge %0d, the pin stream has a gap",
                         $time, cycle);
            end
            // a sampled word shows slot 0 three edges on and slot 1 four edges on
            if (hr_phase == addr_cmd_pkg::PHASE_SLOT1)
            begin
                exp_due.push_back(cycle + 3);
                exp_pins.push_back(slot_pins(0));
                exp_word.push_back(words_sampled);
                exp_slot.push_back(0);
                exp_due.push_back(cycle + 4);
                exp_pins.push_back(slot_pins(1));
                exp_word.push_back(words_sampled);
                exp_slot.push_back(1);
                words_sampled++;
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/addr_cmd_path_tb.sv
// address and command path testbench
`timescale 1ns/1ps
`default_nettype none

module addr_cmd_path_tb;

    localparam int CLK_PERIOD_NS = 40;
    localparam int RESET_CYCLES  = 10;
    localparam int NUM_WORDS     = 16;
    localparam int WATCHDOG_NS   = (RESET_CYCLES + 2 * NUM_WORDS + 20) * CLK_PERIOD_NS;
    localparam int ADDR2_W       = 2 * addr_cmd_pkg::MEM_ADDR_W;
    localparam int ROW_W         = 2 * (addr_cmd_pkg::MEM_ADDR_W + addr_cmd_pkg::MEM_BANK_W
        + addr_cmd_pkg::MEM_CS_W + addr_cmd_pkg::MEM_CKE_W + addr_cmd_pkg::MEM_ODT_W)
        + 8 + addr_cmd_pkg::MEM_CK_W;

    logic                                  pll_mem_clk;
    logic                                  rst_n;
    logic [ADDR2_W-1:0]                    afi_address;
    logic [2*addr_cmd_pkg::MEM_BANK_W-1:0] afi_bank;
    logic [2*addr_cmd_pkg::MEM_CS_W-1:0]   afi_cs_n;
    logic [2*addr_cmd_pkg::MEM_CKE_W-1:0]  afi_cke;
    logic [2*addr_cmd_pkg::MEM_ODT_W-1:0]  afi_odt;
    logic [1:0]                            afi_ras_n;
    logic [1:0]                            afi_cas_n;
    logic [1:0]                            afi_we_n;
    logic [1:0]                            afi_reset_n;
    logic [addr_cmd_pkg::MEM_CK_W-1:0]     enable_mem_clk;
    logic [addr_cmd_pkg::MEM_ADDR_W-1:0]   mem_address;
    logic [addr_cmd_pkg::MEM_BANK_W-1:0]   mem_bank;
    logic [addr_cmd_pkg::MEM_CS_W-1:0]     mem_cs_n;
    logic [addr_cmd_pkg::MEM_CKE_W-1:0]    mem_cke;
    logic [addr_cmd_pkg::MEM_ODT_W-1:0]    mem_odt;
    logic                                  mem_ras_n;
    logic                                  mem_cas_n;
    logic                                  mem_we_n;
    logic                                  mem_reset_n;
    logic                                  cmd_oe;
    logic [addr_cmd_pkg::MEM_CK_W-1:0]     mem_ck_en;
    addr_cmd_pkg::hr_phase_t               hr_phase;
    int                                    error_count;
    int                                    check_count;
    int                                    words_sampled;
    int                                    words_checked;

    // each row is {address, bank, cs_n, cke, odt, ras_n, cas_n, we_n, reset_n, ck_en}
    logic [ROW_W-1:0] stim_rows[$];
    int               stim_gaps[$];
    int               seed = 32'h3d9510c5;
    int               last_word;

    addr_cmd_path DUT (.*);

    addr_cmd_checker u_checker (.*);

    always #(CLK_PERIOD_NS / 2) pll_mem_clk = ~pll_mem_clk;

    function automatic logic [ADDR2_W-1:0] random_address();
        return ADDR2_W'($random(seed));
    endfunction

    // cmd is {ras_n, cas_n, we_n}, two slot bits each, slot 1 high
    task automatic add_entry(input int gap, input logic [ADDR2_W-1:0] addr,
                             input logic [5:0] bank, input logic [1:0] cs_n,
                             input logic [1:0] cke, input logic [1:0] odt,
                             input logic [5:0] cmd, input logic [1:0] reset_n,
                             input logic ck_en);
        stim_rows.push_back({addr, bank, cs_n, cke, odt, cmd, reset_n, ck_en});
        stim_gaps.push_back(gap);
    endtask

    // ******************************************************************
    // stimulus table
    // ******************************************************************

    task automatic build_table();
        // memory held in reset with its clock stopped, then reset released
        add_entry(0, '0, '0, 2'b11, 2'b00, 2'b00, 6'b111111, 2'b00, 1'b0);
        add_entry(0, '0, '0, 2'b11, 2'b00, 2'b00, 6'b111111, 2'b11, 1'b0);
        // clock starts and CKE rises in slot 1
        add_entry(1, '0, '0, 2'b11, 2'b10, 2'b00, 6'b111111, 2'b11, 1'b1);
        add_entry(0, 28'h0004518, 6'b000010, 2'b10, 2'b11, 2'b00, 6'b101010, 2'b11, 1'b1);
        add_entry(0, random_address(), 6'b000101, 2'b10, 2'b11, 2'b00, 6'b101111, 2'b11, 1'b1);
        add_entry(0, random_address(), 6'b101000, 2'b01, 2'b11, 2'b00, 6'b110111, 2'b11, 1'b1);
        add_entry(0, 28'h01A3C40, 6'b000011, 2'b10, 2'b11, 2'b11, 6'b111010, 2'b11, 1'b1);
        // clock gated off while CKE and reset_n keep moving
        add_entry(1, 28'h1234567, 6'b111000, 2'b11, 2'b11, 2'b00, 6'b111111, 2'b11, 1'b0);
        add_entry(0, 28'h3FFC000, 6'b010101, 2'b11, 2'b01, 2'b00, 6'b111111, 2'b11, 1'b0);
        add_entry(0, '0, '0, 2'b01, 2'b11, 2'b00, 6'b010111, 2'b11, 1'b1);
        add_entry(0, random_address(), 6'b110001, 2'b00, 2'b11, 2'b00, 6'b001100, 2'b11, 1'b1);
        add_entry(0, random_address(), 6'b011110, 2'b00, 2'b11, 2'b00, 6'b001111, 2'b11, 1'b1);
        add_entry(1, 28'hFFFFFFF, 6'b100001, 2'b00, 2'b11, 2'b10, 6'b110010, 2'b11, 1'b1);
        add_entry(0, 28'h5555AAA, 6'b111111, 2'b00, 2'b11, 2'b01, 6'b000000, 2'b11, 1'b1);
        add_entry(0, 28'h2AAAAAA, 6'b000000, 2'b11, 2'b11, 2'b00, 6'b111111, 2'b01, 1'b0);
        add_entry(0, '0, '0, 2'b11, 2'b00, 2'b00, 6'b111111, 2'b00, 1'b1);
    endtask

    task automatic drive_word(input logic [ROW_W-1:0] row);
        {afi_address, afi_bank, afi_cs_n, afi_cke, afi_odt,
         afi_ras_n, afi_cas_n, afi_we_n, afi_reset_n, enable_mem_clk} = row;
    endtask

    // returns at a falling edge whose next rising edge samples the inputs
    task automatic wait_for_sample_window();
        do
            @(negedge pll_mem_clk);
        while (hr_phase != addr_cmd_pkg::PHASE_SLOT1);
    endtask

    // ******************************************************************
    // reset, drive loop and summary
    // ******************************************************************

    initial
    begin
        pll_mem_clk    = 1'b0;
        rst_n          = 1'b1;
        afi_address    = '0;
        afi_bank       = '0;
        afi_cs_n       = '1;
        afi_cke        = '0;
        afi_odt        = '0;
        afi_ras_n      = '1;
        afi_cas_n      = '1;
        afi_we_n       = '1;
        afi_reset_n    = '0;
        enable_mem_clk = '0;
        build_table();
        // a real falling edge on rst_n fires the asynchronous reset
        #1;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge pll_mem_clk);
        rst_n = 1'b1;
        for (int i = 0; i < NUM_WORDS; i++)
        begin
            // during a gap the controller keeps repeating its last word
            repeat (stim_gaps[i] + 1) wait_for_sample_window();
            drive_word(stim_rows[i]);
        end
        @(negedge pll_mem_clk);
        last_word = words_sampled;
        wait (words_checked >= last_word);
        @(negedge pll_mem_clk);
        $display("addr_cmd_path_tb: %0d checks, %0d errors, %0d of %0d words checked",
                 check_count, error_count, words_checked, words_sampled);
        if (error_count == 0 && words_checked > 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("addr_cmd_path_tb: timed out after %0d ns with %0d words checked, %0d errors",
                 WATCHDOG_NS, words_checked, error_count);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire
